/* bench/x86_decoder_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module x86_decoder_tb;
    import x86_decode_pkg::*;

    typedef struct packed {
        int          issue;
        int          index;
        logic [47:0] head;
        ea_info_t    expected;
    } pending_t;

    logic     clk;
    logic     rst;
    logic     valid;
    window_t  window;
    logic     default_size_32;
    ea_info_t result;

    logic [47:0] head_q[$];  // first six window bytes with byte 0 leftmost
    logic        size_q[$];
    ea_info_t    expected_q[$];
    pending_t    pending_q[$];

    int          edge_count = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          gap;
    int          wait_cycles;
    logic        timed_out;

    x86_decoder x86_decoder_i (
        .i_clk             (clk),
        .i_rst             (rst),
        .i_valid           (valid),
        .i_window          (window),
        .i_default_size_32 (default_size_32),
        .o_result          (result)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        edge_count++;
    end

    // memory operand result
    function automatic ea_info_t ea(input adc_form_e form, input int w, input logic [2:0] seg,
                                    input int base_p, input int base, input int index_p,
                                    input int index, input int scale, input disp_size_e disp,
                                    input int err);
        ea_info_t e;
        e                   = '0;
        e.valid             = 1'b1;
        e.form              = form;
        e.w                 = 1'(w);
        e.is_memory         = 1'b1;
        e.segment_reg_index = seg;
        e.base_present      = 1'(base_p);
        e.base_index        = 3'(base);
        e.index_present     = 1'(index_p);
        e.index_index       = 3'(index);
        e.scale             = 2'(scale);
        e.disp_size         = disp;
        e.error             = 1'(err);
        return e;
    endfunction

    // register operand or no modrm leaves all address fields zero
    function automatic ea_info_t no_mem(input adc_form_e form, input int w, input int err);
        ea_info_t e;
        e       = '0;
        e.valid = 1'b1;
        e.form  = form;
        e.w     = 1'(w);
        e.error = 1'(err);
        return e;
    endfunction

    task automatic add_case(input logic [47:0] head, input logic size_32, input ea_info_t exp);
        head_q.push_back(head);
        size_q.push_back(size_32);
        expected_q.push_back(exp);
    endtask

    task automatic load_table();
        // 16-bit, mod 00
        add_case(48'h110000000000, 0, ea(ADC_RM_REG, 1, SEG_DS, 1, 3, 1, 6, 0, DISP_NONE, 0));
        add_case(48'h110100000000, 0, ea(ADC_RM_REG, 1, SEG_DS, 1, 3, 1, 7, 0, DISP_NONE, 0));
        add_case(48'h110200000000, 0, ea(ADC_RM_REG, 1, SEG_SS, 1, 5, 1, 6, 0, DISP_NONE, 0));
        add_case(48'h110300000000, 0, ea(ADC_RM_REG, 1, SEG_SS, 1, 5, 1, 7, 0, DISP_NONE, 0));
        add_case(48'h110400000000, 0, ea(ADC_RM_REG, 1, SEG_DS, 1, 6, 0, 0, 0, DISP_NONE, 0));
        add_case(48'h110500000000, 0, ea(ADC_RM_REG, 1, SEG_DS, 1, 7, 0, 0, 0, DISP_NONE, 0));
        add_case(48'h110600000000, 0, ea(ADC_RM_REG, 1, SEG_DS, 0, 0, 0, 0, 0, DISP_16, 0));
        add_case(48'h110700000000, 0, ea(ADC_RM_REG, 1, SEG_DS, 1, 3, 0, 0, 0, DISP_NONE, 0));
        // 16-bit, mod 01
        add_case(48'h124000000000, 0, ea(ADC_REG_RM, 0, SEG_DS, 1, 3, 1, 6, 0, DISP_8, 0));
        add_case(48'h124100000000, 0, ea(ADC_REG_RM, 0, SEG_DS, 1, 3, 1, 7, 0, DISP_8, 0));
        add_case(48'h124200000000, 0, ea(ADC_REG_RM, 0, SEG_SS, 1, 5, 1, 6, 0, DISP_8, 0));
        add_case(48'h124300000000, 0, ea(ADC_REG_RM, 0, SEG_SS, 1, 5, 1, 7, 0, DISP_8, 0));
        add_case(48'h124400000000, 0, ea(ADC_REG_RM, 0, SEG_DS, 1, 6, 0, 0, 0, DISP_8, 0));
        add_case(48'h124500000000, 0, ea(ADC_REG_RM, 0, SEG_DS, 1, 7, 0, 0, 0, DISP_8, 0));
        add_case(48'h124600000000, 0, ea(ADC_REG_RM, 0, SEG_SS, 1, 5, 0, 0, 0, DISP_8, 0));
        add_case(48'h124700000000, 0, ea(ADC_REG_RM, 0, SEG_DS, 1, 3, 0, 0, 0, DISP_8, 0));
        // 16-bit, mod 10
        add_case(48'h108000000000, 0, ea(ADC_RM_REG, 0, SEG_DS, 1, 3, 1, 6, 0, DISP_16, 0));
        add_case(48'h108100000000, 0, ea(ADC_RM_REG, 0, SEG_DS, 1, 3, 1, 7, 0, DISP_16, 0));
        add_case(48'h108200000000, 0, ea(ADC_RM_REG, 0, SEG_SS, 1, 5, 1, 6, 0, DISP_16, 0));
        add_case(48'h108300000000, 0, ea(ADC_RM_REG, 0, SEG_SS, 1, 5, 1, 7, 0, DISP_16, 0));
        add_case(48'h108400000000, 0, ea(ADC_RM_REG, 0, SEG_DS, 1, 6, 0, 0, 0, DISP_16, 0));
        add_case(48'h108500000000, 0, ea(ADC_RM_REG, 0, SEG_DS, 1, 7, 0, 0, 0, DISP_16, 0));
        add_case(48'h108600000000, 0, ea(ADC_RM_REG, 0, SEG_SS, 1, 5, 0, 0, 0, DISP_16, 0));
        add_case(48'h108700000000, 0, ea(ADC_RM_REG, 0, SEG_DS, 1, 3, 0, 0, 0, DISP_16, 0));
        // 32-bit plain rm
        add_case(48'h130000000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 0, 0, 0, 0, DISP_NONE, 0));
        add_case(48'h134500000000, 1, ea(ADC_REG_RM, 1, SEG_SS, 1, 5, 0, 0, 0, DISP_8, 0));
        add_case(48'h138300000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 3, 0, 0, 0, DISP_32, 0));
        add_case(48'h130500000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 0, 0, 0, 0, 0, DISP_32, 0));
        add_case(48'h13c100000000, 1, no_mem(ADC_REG_RM, 1, 0));
        // 32-bit sib
        add_case(48'h130408000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 0, 1, 1, 0, DISP_NONE, 0));
        add_case(48'h13044b000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 3, 1, 1, 1, DISP_NONE, 0));
        add_case(48'h130493000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 3, 1, 2, 2, DISP_NONE, 0));
        add_case(48'h1304f1000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 1, 1, 6, 3, DISP_NONE, 0));
        add_case(48'h130420000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 0, 0, 0, 0, DISP_NONE, 0));
        add_case(48'h13040d000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 0, 0, 1, 1, 0, DISP_32, 0));
        add_case(48'h134424000000, 1, ea(ADC_REG_RM, 1, SEG_SS, 1, 4, 0, 0, 0, DISP_8, 0));
        add_case(48'h138488000000, 1, ea(ADC_REG_RM, 1, SEG_DS, 1, 0, 1, 1, 2, DISP_32, 0));
        // prefixes
        add_case(48'h641046000000, 1, ea(ADC_RM_REG, 0, SEG_FS, 1, 6, 0, 0, 0, DISP_8, 0));
        add_case(48'h2e1046000000, 0, ea(ADC_RM_REG, 0, SEG_CS, 1, 5, 0, 0, 0, DISP_8, 0));
        add_case(48'h642610460000, 0, ea(ADC_RM_REG, 0, SEG_ES, 1, 5, 0, 0, 0, DISP_8, 0));
        add_case(48'h671006000000, 0, ea(ADC_RM_REG, 0, SEG_DS, 1, 6, 0, 0, 0, DISP_NONE, 0));
        add_case(48'h671006000000, 1, ea(ADC_RM_REG, 0, SEG_DS, 0, 0, 0, 0, 0, DISP_16, 0));
        add_case(48'hf3663e671142, 1, ea(ADC_RM_REG, 1, SEG_DS, 1, 5, 1, 6, 0, DISP_8, 0));
        add_case(48'hf03666f21300, 0, ea(ADC_REG_RM, 1, SEG_SS, 1, 3, 1, 6, 0, DISP_NONE, 0));
        // immediate forms
        add_case(48'h801600000000, 0, ea(ADC_IMM_RM, 0, SEG_DS, 0, 0, 0, 0, 0, DISP_16, 0));
        add_case(48'h815424000000, 1, ea(ADC_IMM_RM, 1, SEG_SS, 1, 4, 0, 0, 0, DISP_8, 0));
        add_case(48'h83d000000000, 1, no_mem(ADC_IMM_RM, 1, 0));
        add_case(48'h150000000000, 1, no_mem(ADC_IMM_ACC, 1, 0));
        add_case(48'h14c300000000, 0, no_mem(ADC_IMM_ACC, 0, 0));
        // error cases
        add_case(48'h8b4500000000, 1, no_mem(ADC_NONE, 1, 1));
        add_case(48'h80d800000000, 0, no_mem(ADC_NONE, 0, 1));
        add_case(48'hf010c0000000, 0, no_mem(ADC_RM_REG, 0, 1));
        add_case(48'hf01400000000, 1, no_mem(ADC_IMM_ACC, 0, 1));
        add_case(48'hf01500000000, 0, no_mem(ADC_IMM_ACC, 1, 1));
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t ns: %s got 0x%h expected 0x%h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input pending_t entry, input logic seen);
        int errors_start;
        errors_start = errors;
        if (seen) begin
            compare_value("o_result", 32'(result), 32'(entry.expected));
            compare_value("latency", edge_count - entry.issue, 3);
        end
        tests_run++;
        if (seen && errors == errors_start) begin
            $display("test %0d window %h: ok", entry.index, entry.head);
        end else begin
            tests_failed++;
            $display("test %0d window %h: failed", entry.index, entry.head);
        end
    endtask

    task automatic apply_entry(input int i);
        pending_t entry;
        valid           = 1'b1;
        window          = {head_q[i], 80'h0};
        default_size_32 = size_q[i];
        entry.issue     = edge_count;
        entry.index     = i;
        entry.head      = head_q[i];
        entry.expected  = expected_q[i];
        pending_q.push_back(entry);
    endtask

    // result checker, one queue entry per valid
    always @(negedge clk) begin
        if (!rst) begin
            if (result.valid === 1'b1) begin
                if (pending_q.size() == 0) begin
                    $display("Error at %0t ns: o_result valid with no window in flight", $time);
                    errors++;
                end else begin
                    finish_test(pending_q.pop_front(), 1'b1);
                end
            end else if (result.valid !== 1'b0) begin
                $display("Error at %0t ns: o_result valid is unknown", $time);
                errors++;
            end else if (pending_q.size() != 0 && edge_count - pending_q[0].issue >= 3) begin
                $display("Error at %0t ns: no result for test %0d", $time, pending_q[0].index);
                errors++;
                finish_test(pending_q.pop_front(), 1'b0);
            end
        end
    end

    initial begin
        void'($urandom(32'hea371ee4));
        clk             = 1'b0;
        rst             = 1'b1;
        valid           = 1'b0;
        window          = '0;
        default_size_32 = 1'b0;
        timed_out       = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < head_q.size(); i++) begin
            gap = (i >= head_q.size() - 10) ? 0 : int'($urandom % 3);  // tail runs back to back
            repeat (gap) begin
                @(posedge clk);
                #1;
                valid = 1'b0;
            end
            @(posedge clk);
            #1;
            apply_entry(i);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        wait_cycles = 0;
        while (pending_q.size() != 0 && wait_cycles < 12) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pending_q.size() != 0) begin
            $display("Timeout: %0d results never came out of the decoder", pending_q.size());
            timed_out = 1'b1;
        end
        wait_cycles = 0;
        while (wait_cycles < 4) begin  // idle tail must show no stray valids
            @(negedge clk);
            wait_cycles++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out && tests_run == head_q.size()) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/decode_address.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_address (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  x86_decode_pkg::opcode_info_t i_info,
    output x86_decode_pkg::ea_info_t     o_result
);
    import x86_decode_pkg::*;

    ea_info_t   result_next;
    logic       mod_rm_is_memory;
    logic       mod_rm_sib_present;
    logic       mod_rm_base_present;
    logic [2:0] mod_rm_base_index;
    logic       mod_rm_index_present;
    logic [2:0] mod_rm_index_index;
    disp_size_e mod_rm_disp_size;
    logic [2:0] mod_rm_default_seg;
    logic [1:0] sib_scale;
    logic       sib_index_present;
    logic [2:0] sib_index_index;
    logic       sib_base_present;
    logic [2:0] sib_base_index;
    disp_size_e sib_disp_size;
    logic [2:0] sib_default_seg;
    logic       register_operand;

    decode_mod_rm decode_mod_rm_i (
        .i_mod             (i_info.mod),
        .i_rm              (i_info.rm),
        .i_address_size_32 (i_info.address_size_32),
        .o_is_memory       (mod_rm_is_memory),
        .o_sib_present     (mod_rm_sib_present),
        .o_base_present    (mod_rm_base_present),
        .o_base_index      (mod_rm_base_index),
        .o_index_present   (mod_rm_index_present),
        .o_index_index     (mod_rm_index_index),
        .o_disp_size       (mod_rm_disp_size),
        .o_default_seg     (mod_rm_default_seg)
    );

    decode_sib decode_sib_i (
        .i_sib           (i_info.sib),
        .i_mod           (i_info.mod),
        .o_scale         (sib_scale),
        .o_index_present (sib_index_present),
        .o_index_index   (sib_index_index),
        .o_base_present  (sib_base_present),
        .o_base_index    (sib_base_index),
        .o_disp_size     (sib_disp_size),
        .o_default_seg   (sib_default_seg)
    );

    assign register_operand = i_info.mod_rm_present & ~mod_rm_is_memory;

    always_comb begin
        result_next       = '0;
        result_next.valid = i_info.valid;
        result_next.form  = i_info.form;
        result_next.w     = i_info.w;
        if (i_info.mod_rm_present && mod_rm_is_memory) begin  // imm to acc skips this
            result_next.is_memory = 1'b1;
            if (mod_rm_sib_present) begin
                result_next.segment_reg_index = sib_default_seg;
                result_next.base_present      = sib_base_present;
                result_next.base_index        = sib_base_index;
                result_next.index_present     = sib_index_present;
                result_next.index_index       = sib_index_index;
                result_next.scale             = sib_scale;
                result_next.disp_size         = sib_disp_size;
            end else begin
                result_next.segment_reg_index = mod_rm_default_seg;
                result_next.base_present      = mod_rm_base_present;
                result_next.base_index        = mod_rm_base_index;
                result_next.index_present     = mod_rm_index_present;
                result_next.index_index       = mod_rm_index_index;
                result_next.disp_size         = mod_rm_disp_size;
            end
            if (i_info.seg_override_present) begin
                result_next.segment_reg_index = i_info.seg_override_index;
            end
        end
        result_next.error = i_info.error |
                            (i_info.lock & register_operand) |
                            (i_info.lock & (i_info.form == ADC_IMM_ACC));
    end

    always_ff @(posedge i_clk) begin
        o_result <= result_next;
        if (i_rst) begin
            o_result.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/decode_mod_rm.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_mod_rm (
    input  logic [1:0]                 i_mod,
    input  logic [2:0]                 i_rm,
    input  logic                       i_address_size_32,
    output logic                       o_is_memory,
    output logic                       o_sib_present,
    output logic                       o_base_present,
    output logic [2:0]                 o_base_index,
    output logic                       o_index_present,
    output logic [2:0]                 o_index_index,
    output x86_decode_pkg::disp_size_e o_disp_size,
    output logic [2:0]                 o_default_seg
);
    import x86_decode_pkg::*;

    always_comb begin
        o_is_memory     = 1'b0;
        o_sib_present   = 1'b0;
        o_base_present  = 1'b0;
        o_base_index    = 3'd0;
        o_index_present = 1'b0;
        o_index_index   = 3'd0;
        o_disp_size     = DISP_NONE;
        o_default_seg   = SEG_DS;
        if (i_mod != 2'b11) begin
            o_is_memory = 1'b1;
            if (i_address_size_32) begin
                o_disp_size = (i_mod == 2'b01) ? DISP_8 :
                              (i_mod == 2'b10) ? DISP_32 : DISP_NONE;
                if (i_rm == 3'b100) begin
                    o_sib_present = 1'b1;  // regs come from sib
                end else if (i_mod == 2'b00 && i_rm == 3'b101) begin
                    o_disp_size = DISP_32;  // disp32 only
                end else begin
                    o_base_present = 1'b1;
                    o_base_index   = i_rm;
                    if (i_rm == REG_BP) begin
                        o_default_seg = SEG_SS;
                    end
                end
            end else begin
                o_disp_size = (i_mod == 2'b01) ? DISP_8 :
                              (i_mod == 2'b10) ? DISP_16 : DISP_NONE;
                o_base_present = 1'b1;
                case (i_rm)
                    3'b000: {o_base_index, o_index_index} = {REG_BX, REG_SI};
                    3'b001: {o_base_index, o_index_index} = {REG_BX, REG_DI};
                    3'b010: {o_base_index, o_index_index} = {REG_BP, REG_SI};
                    3'b011: {o_base_index, o_index_index} = {REG_BP, REG_DI};
                    3'b100: o_base_index = REG_SI;
                    3'b101: o_base_index = REG_DI;
                    3'b110: o_base_index = REG_BP;
                    default: o_base_index = REG_BX;
                endcase
                o_index_present = ~i_rm[2];  // two-register forms
                if (i_mod == 2'b00 && i_rm == 3'b110) begin
                    o_base_present = 1'b0;  // direct disp16
                    o_base_index   = 3'd0;
                    o_disp_size    = DISP_16;
                end else if (o_base_index == REG_BP) begin
                    o_default_seg = SEG_SS;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/decode_opcode.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_opcode (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  x86_decode_pkg::prefix_info_t i_info,
    output x86_decode_pkg::opcode_info_t o_info
);
    import x86_decode_pkg::*;

    opcode_info_t info_next;
    logic [3:0]   opcode_offset;
    logic [7:0]   opcode;
    logic [7:0]   mod_rm;

    assign opcode_offset = {1'b0, i_info.prefix_count};
    assign opcode        = i_info.window[opcode_offset];
    assign mod_rm        = i_info.window[opcode_offset + 4'd1];  // byte after opcode

    always_comb begin
        info_next                      = '0;
        info_next.valid                = i_info.valid;
        info_next.w                    = opcode[0];
        info_next.s                    = (opcode == 8'h83);
        info_next.mod                  = mod_rm[7:6];
        info_next.reg_field            = mod_rm[5:3];
        info_next.rm                   = mod_rm[2:0];
        info_next.sib                  = i_info.window[opcode_offset + 4'd2];
        info_next.seg_override_present = i_info.seg_override_present;
        info_next.seg_override_index   = i_info.seg_override_index;
        info_next.lock                 = i_info.lock;
        info_next.address_size_32      = i_info.address_size_32;
        case (opcode)
            8'h10, 8'h11: begin
                info_next.form           = ADC_RM_REG;
                info_next.mod_rm_present = 1'b1;
            end
            8'h12, 8'h13: begin
                info_next.form           = ADC_REG_RM;
                info_next.mod_rm_present = 1'b1;
            end
            8'h14, 8'h15: begin
                info_next.form = ADC_IMM_ACC;  // al/ax/eax, no modrm
            end
            8'h80, 8'h81, 8'h83: begin
                info_next.mod_rm_present = 1'b1;
                if (mod_rm[5:3] == 3'b010) begin  // group 1 /2 is adc
                    info_next.form = ADC_IMM_RM;
                end else begin
                    info_next.error = 1'b1;
                end
            end
            default: begin
                info_next.error = 1'b1;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        o_info <= info_next;
        if (i_rst) begin
            o_info.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/decode_prefix.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_prefix (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_valid,
    input  x86_decode_pkg::window_t      i_window,
    input  logic                         i_default_size_32,
    output x86_decode_pkg::prefix_info_t o_info
);
    import x86_decode_pkg::*;

    prefix_info_t info_next;
    logic         scan_done;
    logic         operand_toggle;
    logic         address_toggle;

    always_comb begin
        info_next      = '0;
        scan_done      = 1'b0;
        operand_toggle = 1'b0;
        address_toggle = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!scan_done) begin
                if (i_window[i] inside {8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65}) begin
                    info_next.seg_override_present = 1'b1;
                end
                case (i_window[i])
                    8'hf0: info_next.lock = 1'b1;
                    8'hf2, 8'hf3: ;  // rep is only counted
                    8'h26: info_next.seg_override_index = SEG_ES;
                    8'h2e: info_next.seg_override_index = SEG_CS;
                    8'h36: info_next.seg_override_index = SEG_SS;
                    8'h3e: info_next.seg_override_index = SEG_DS;
                    8'h64: info_next.seg_override_index = SEG_FS;
                    8'h65: info_next.seg_override_index = SEG_GS;
                    8'h66: operand_toggle = 1'b1;
                    8'h67: address_toggle = 1'b1;
                    default: scan_done = 1'b1;  // opcode reached
                endcase
                if (!scan_done) begin
                    info_next.prefix_count = info_next.prefix_count + 3'd1;
                end
            end
        end
        info_next.valid           = i_valid;
        info_next.window          = i_window;
        info_next.operand_size_32 = i_default_size_32 ^ operand_toggle;
        info_next.address_size_32 = i_default_size_32 ^ address_toggle;
    end

    always_ff @(posedge i_clk) begin
        o_info <= info_next;
        if (i_rst) begin
            o_info.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/decode_sib.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_sib (
    input  logic [7:0]                 i_sib,
    input  logic [1:0]                 i_mod,
    output logic [1:0]                 o_scale,
    output logic                       o_index_present,
    output logic [2:0]                 o_index_index,
    output logic                       o_base_present,
    output logic [2:0]                 o_base_index,
    output x86_decode_pkg::disp_size_e o_disp_size,
    output logic [2:0]                 o_default_seg
);
    import x86_decode_pkg::*;

    assign o_scale         = i_sib[7:6];
    assign o_index_present = (i_sib[5:3] != 3'b100);  // esp cannot index
    assign o_index_index   = o_index_present ? i_sib[5:3] : 3'd0;

    always_comb begin
        if (i_sib[2:0] == 3'b101 && i_mod == 2'b00) begin
            o_base_present = 1'b0;  // disp32 without base
            o_base_index   = 3'd0;
            o_disp_size    = DISP_32;
            o_default_seg  = SEG_DS;
        end else begin
            o_base_present = 1'b1;
            o_base_index   = i_sib[2:0];
            o_disp_size    = (i_mod == 2'b01) ? DISP_8 :
                             (i_mod == 2'b10) ? DISP_32 : DISP_NONE;
            o_default_seg  = (i_sib[2:1] == 2'b10) ? SEG_SS : SEG_DS;  // esp or ebp
        end
    end

endmodule

`default_nettype wire

/* hw/x86_decode_pkg.sv */
`default_nettype none

package x86_decode_pkg;

    typedef logic [0:15][7:0] window_t;  // window[0] is the first byte

    localparam logic [2:0] SEG_ES = 3'd0;
    localparam logic [2:0] SEG_CS = 3'd1;
    localparam logic [2:0] SEG_SS = 3'd2;
    localparam logic [2:0] SEG_DS = 3'd3;
    localparam logic [2:0] SEG_FS = 3'd4;
    localparam logic [2:0] SEG_GS = 3'd5;

    // general register codes as they appear in rm and SIB fields
    localparam logic [2:0] REG_BX = 3'd3;
    localparam logic [2:0] REG_BP = 3'd5;
    localparam logic [2:0] REG_SI = 3'd6;
    localparam logic [2:0] REG_DI = 3'd7;

    typedef enum logic [2:0] {
        ADC_NONE,
        ADC_RM_REG,
        ADC_REG_RM,
        ADC_IMM_ACC,
        ADC_IMM_RM
    } adc_form_e;

    typedef enum logic [1:0] {
        DISP_NONE,
        DISP_8,
        DISP_16,
        DISP_32
    } disp_size_e;

    typedef struct packed {
        logic       valid;
        window_t    window;
        logic [2:0] prefix_count;
        logic       seg_override_present;
        logic [2:0] seg_override_index;
        logic       lock;
        logic       operand_size_32;
        logic       address_size_32;
    } prefix_info_t;

    typedef struct packed {
        logic       valid;
        adc_form_e  form;
        logic       w;
        logic       s;
        logic       mod_rm_present;
        logic [1:0] mod;
        logic [2:0] reg_field;
        logic [2:0] rm;
        logic [7:0] sib;
        logic       seg_override_present;
        logic [2:0] seg_override_index;
        logic       lock;
        logic       address_size_32;
        logic       error;
    } opcode_info_t;

    typedef struct packed {
        logic       valid;
        adc_form_e  form;
        logic       w;
        logic       is_memory;
        logic [2:0] segment_reg_index;
        logic       base_present;
        logic [2:0] base_index;
        logic       index_present;
        logic [2:0] index_index;
        logic [1:0] scale;
        disp_size_e disp_size;
        logic       error;
    } ea_info_t;

endpackage

`default_nettype wire

/* hw/x86_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module x86_decoder (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_valid,
    input  x86_decode_pkg::window_t  i_window,
    input  logic                     i_default_size_32,  // code segment D bit
    output x86_decode_pkg::ea_info_t o_result
);
    import x86_decode_pkg::*;

    prefix_info_t prefix_info;
    opcode_info_t opcode_info;

    decode_prefix decode_prefix_i (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_valid           (i_valid),
        .i_window          (i_window),
        .i_default_size_32 (i_default_size_32),
        .o_info            (prefix_info)
    );

    decode_opcode decode_opcode_i (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_info (prefix_info),
        .o_info (opcode_info)
    );

    decode_address decode_address_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_info   (opcode_info),
        .o_result (o_result)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the decoder testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module x86_decoder_tb \
    -f x86_decoder.f -o x86_decoder_sim &&
./obj_dir/x86_decoder_sim | tee /dev/stderr | grep -qx "Simulation finished: PASS" &&
echo "run_sim: simulation passed" ||
{
    echo "run_sim: simulation failed"
    exit 1
}

/* x86_decoder.f */
hw/x86_decode_pkg.sv
hw/decode_prefix.sv
hw/decode_opcode.sv
hw/decode_mod_rm.sv
hw/decode_sib.sv
hw/decode_address.sv
hw/x86_decoder.sv
bench/x86_decoder_tb.sv
